//--- vlog.f
+incdir+include
logic/tcm_pkg.sv
logic/tcm_tdpram.sv
logic/tcm_cpu_port.sv
logic/tcm_axil_slave.sv
logic/tcm_top.sv
bench/tcm_chk.sv
bench/tcm_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the TCM testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f vlog.f --top-module tcm_tb -Mdir obj_dir \
   && ./obj_dir/Vtcm_tb | tee /dev/stderr | grep -qx "sim passed" \
   && { echo "run.sh: simulation ok"; exit 0; } \
   || { echo "run.sh: simulation or build failed"; exit 1; }

//--- bench/tcm_tb.sv
`timescale 1ns/1ps
`include "tcm_macros.svh"

module tcm_tb;
   import tcm_pkg::*;

   localparam int words       = 1 << `TCM_AW;
   localparam int stall_limit = 32;
   localparam int rt_words    = 16;
   localparam int cpu_words   = 8;
   // Upper bounds on bus transactions and CPU requests issued
   localparam int axi_txns    = 2 * rt_words + cpu_words + 12;
   localparam int cpu_ops     = 2 * cpu_words + 16;
   localparam int watchdog_cycles = 3 + axi_txns * (2 * stall_limit + 4) + cpu_ops * 2 + 200;

   logic      clk = 1'b0;
   logic      rst_n;
   axil_aw_t  aw;
   logic      aw_valid;
   logic      aw_ready;
   axil_w_t   w;
   logic      w_valid;
   logic      w_ready;
   axil_ar_t  ar;
   logic      ar_valid;
   logic      ar_ready;
   axil_b_t   b;
   logic      b_valid;
   logic      b_ready;
   axil_r_t   r;
   logic      r_valid;
   logic      r_ready;
   cpu_req_t  cpu_req;
   cpu_rsp_t  cpu_rsp;

   // Reference contents of the RAM
   tcm_data_t model [words];
   int        checks;
   int        value_errors;
   int        other_errors;

   tcm_top uut (
      .clk      (clk),
      .rst_n    (rst_n),
      .aw       (aw),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .w        (w),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .ar       (ar),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .b        (b),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .r        (r),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .cpu_req  (cpu_req),
      .cpu_rsp  (cpu_rsp)
   );

   bind tcm_tdpram tcm_chk u_chk (
      .clk      (clk),
      .rst_n    (rst_n),
      .en_a     (en_a),
      .we_a     (we_a),
      .addr_a   (addr_a),
      .en_b     (en_b),
      .we_b     (we_b),
      .addr_b   (addr_b),
      .dout_a   (dout_a),
      .bypass_q (bypass_q)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   // Hard stop in case a handshake never completes
   initial begin : watchdog
      #(watchdog_cycles * 4);
      other_errors++;
      $display("Watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
      $display("Checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      $display("sim failed");
      $finish;
   end

   task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic report_stall(input string what);
      $display("Gave up waiting for %s after %0d cycles", what, stall_limit);
      other_errors++;
   endtask

   function automatic logic coin();
      logic [31:0] v;
      v = $urandom;
      return v[0];
   endfunction

   function automatic tcm_baddr_t byte_addr(input tcm_waddr_t wa);
      tcm_baddr_t a;
      a = '0;
      a[`TCM_AW+1:2] = wa;
      return a;
   endfunction

   // Holds the request until its ready, returns on the negedge after the transfer
   task automatic wait_accept(input logic is_read);
      int n;
      n = 0;
      #1;
      while (!(is_read ? ar_ready : (aw_ready && w_ready)) && n < stall_limit) begin
         @(negedge clk);
         #1;
         n++;
      end
      if (n == stall_limit) begin
         report_stall(is_read ? "arready" : "awready and wready");
      end
      @(negedge clk);
   endtask

   // Random bready, B payload must not move while it waits
   task automatic wait_bresp(output tcm_resp_t resp);
      logic      rdy;
      logic      seen;
      logic      done;
      tcm_resp_t held;
      int        n;
      seen = 1'b0;
      done = 1'b0;
      held = '0;
      resp = '0;
      n    = 0;
      while (!done && n < stall_limit) begin
         rdy     = coin();
         b_ready = rdy;
         #1;
         if (b_valid) begin
            if (seen) begin
               expect_eq("bresp stable", 32'(held), 32'(b.resp));
            end
            held = b.resp;
            seen = 1'b1;
            if (rdy) begin
               done = 1'b1;
               resp = b.resp;
            end
         end
         @(negedge clk);
         n++;
      end
      b_ready = 1'b0;
      if (!done) begin
         report_stall("bvalid");
      end
      expect_eq("bvalid after transfer", 32'd0, 32'(b_valid));
   endtask

   // Random rready, data and response held while waiting
   task automatic wait_rresp(output tcm_data_t data, output tcm_resp_t resp);
      logic    rdy;
      logic    seen;
      logic    done;
      axil_r_t held;
      int      n;
      seen = 1'b0;
      done = 1'b0;
      held = '0;
      data = '0;
      resp = '0;
      n    = 0;
      while (!done && n < stall_limit) begin
         rdy     = coin();
         r_ready = rdy;
         #1;
         if (r_valid) begin
            if (seen) begin
               expect_eq("rdata stable", held.data, r.data);
               expect_eq("rresp stable", 32'(held.resp), 32'(r.resp));
            end
            held = r;
            seen = 1'b1;
            if (rdy) begin
               done = 1'b1;
               data = r.data;
               resp = r.resp;
            end
         end
         @(negedge clk);
         n++;
      end
      r_ready = 1'b0;
      if (!done) begin
         report_stall("rvalid");
      end
      expect_eq("rvalid after transfer", 32'd0, 32'(r_valid));
   endtask

   task automatic axi_write(input tcm_baddr_t addr, input tcm_data_t data,
                            input tcm_strb_t strb, output tcm_resp_t resp);
      aw.addr  = addr;
      w.data   = data;
      w.strb   = strb;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      wait_accept(1'b0);
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      wait_bresp(resp);
   endtask

   task automatic axi_read(input tcm_baddr_t addr, output tcm_data_t data,
                           output tcm_resp_t resp);
      ar.addr  = addr;
      ar_valid = 1'b1;
      wait_accept(1'b1);
      ar_valid = 1'b0;
      wait_rresp(data, resp);
   endtask

   // One CPU request, response checked one cycle later, idle cycle after
   task automatic cpu_op(input string name, input logic we, input tcm_baddr_t addr,
                         input tcm_data_t wdata);
      logic       legal;
      tcm_waddr_t wa;
      tcm_data_t  held;
      // In range and word aligned
      legal = (addr < (32'd4 << `TCM_AW)) && (addr % 4 == 0);
      wa    = addr[`TCM_AW+1:2];
      cpu_req.valid = 1'b1;
      cpu_req.we    = we;
      cpu_req.addr  = addr;
      cpu_req.wdata = wdata;
      @(negedge clk);
      cpu_req.valid = 1'b0;
      cpu_req.we    = 1'b0;
      expect_eq({name, " valid"}, 32'd1, 32'(cpu_rsp.valid));
      expect_eq({name, " err"}, 32'(!legal), 32'(cpu_rsp.err));
      if (legal && !we) begin
         expect_eq({name, " rdata"}, model[wa], cpu_rsp.rdata);
      end
      if (legal && we) begin
         model[wa] = wdata;
      end
      held = cpu_rsp.rdata;
      @(negedge clk);
      expect_eq({name, " idle valid"}, 32'd0, 32'(cpu_rsp.valid));
      expect_eq({name, " rdata hold"}, held, cpu_rsp.rdata);
   endtask

   initial begin : main
      tcm_resp_t  resp;
      tcm_data_t  data;
      tcm_data_t  d_axi;
      tcm_data_t  d_cpu;
      tcm_data_t  old;
      tcm_waddr_t wa;
      tcm_strb_t  strb;
      tcm_baddr_t far;
      tcm_waddr_t rt_list [$];
      tcm_waddr_t cpu_list [$];
      int         i;

      void'($urandom(32'hccd3dc98));
      checks       = 0;
      value_errors = 0;
      other_errors = 0;
      for (i = 0; i < words; i++) begin
         model[i] = '0;
      end
      rst_n    = 1'b0;
      aw       = '0;
      aw_valid = 1'b0;
      w        = '0;
      w_valid  = 1'b0;
      ar       = '0;
      ar_valid = 1'b0;
      b_ready  = 1'b0;
      r_ready  = 1'b0;
      cpu_req  = '0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;

      // Outputs after reset
      expect_eq("reset awready", 32'd0, 32'(aw_ready));
      expect_eq("reset wready", 32'd0, 32'(w_ready));
      expect_eq("reset bvalid", 32'd0, 32'(b_valid));
      expect_eq("reset rvalid", 32'd0, 32'(r_valid));
      expect_eq("reset cpu valid", 32'd0, 32'(cpu_rsp.valid));
      expect_eq("reset bypass flag", 32'd0, 32'(uut.u_tdpram.bypass_q));

      // Bus round trip under back-pressure
      for (i = 0; i < rt_words; i++) begin
         wa   = tcm_waddr_t'($urandom);
         data = tcm_data_t'($urandom);
         rt_list.push_back(wa);
         axi_write(byte_addr(wa), data, '1, resp);
         expect_eq("rt write resp", 32'(`TCM_RESP_OKAY), 32'(resp));
         model[wa] = data;
      end
      foreach (rt_list[k]) begin
         axi_read(byte_addr(rt_list[k]), data, resp);
         expect_eq("rt read resp", 32'(`TCM_RESP_OKAY), 32'(resp));
         expect_eq("rt read data", model[rt_list[k]], data);
      end

      // CPU writes then reads, one cycle latency
      for (i = 0; i < cpu_words; i++) begin
         wa = tcm_waddr_t'($urandom);
         cpu_list.push_back(wa);
         cpu_op("lat write", 1'b1, byte_addr(wa), tcm_data_t'($urandom));
      end
      foreach (cpu_list[k]) begin
         cpu_op("lat read", 1'b0, byte_addr(cpu_list[k]), '0);
      end
      // CPU data seen from the bus
      foreach (cpu_list[k]) begin
         axi_read(byte_addr(cpu_list[k]), data, resp);
         expect_eq("lat bus resp", 32'(`TCM_RESP_OKAY), 32'(resp));
         expect_eq("lat bus data", model[cpu_list[k]], data);
      end

      // Bypass, CPU reads the word each cycle while the bus write lands
      wa    = tcm_waddr_t'($urandom);
      d_axi = tcm_data_t'($urandom);
      old   = model[wa];
      cpu_req.valid = 1'b1;
      cpu_req.we    = 1'b0;
      cpu_req.addr  = byte_addr(wa);
      @(negedge clk);
      expect_eq("bypass early read", old, cpu_rsp.rdata);
      aw.addr  = byte_addr(wa);
      w.data   = d_axi;
      w.strb   = '1;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      #1;
      expect_eq("bypass accept", 32'd1, 32'(aw_ready && w_ready));
      // Landing cycle begins
      @(negedge clk);
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      expect_eq("bypass read at accept", old, cpu_rsp.rdata);
      @(negedge clk);
      cpu_req.valid = 1'b0;
      expect_eq("bypass landing valid", 32'd1, 32'(cpu_rsp.valid));
      expect_eq("bypass landing read", d_axi, cpu_rsp.rdata);
      model[wa] = d_axi;
      // Port A idle, flag keeps the captured word
      @(negedge clk);
      expect_eq("bypass hold", d_axi, cpu_rsp.rdata);
      wait_bresp(resp);
      expect_eq("bypass write resp", 32'(`TCM_RESP_OKAY), 32'(resp));
      cpu_op("bypass reread", 1'b0, byte_addr(wa), '0);

      // Bus and CPU write one word in cycle W, bus lands last
      wa    = tcm_waddr_t'($urandom);
      d_axi = tcm_data_t'($urandom);
      d_cpu = tcm_data_t'($urandom);
      aw.addr  = byte_addr(wa);
      w.data   = d_axi;
      w.strb   = '1;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      #1;
      expect_eq("ww accept", 32'd1, 32'(aw_ready && w_ready));
      @(negedge clk);
      aw_valid      = 1'b0;
      w_valid       = 1'b0;
      cpu_req.valid = 1'b1;
      cpu_req.we    = 1'b1;
      cpu_req.addr  = byte_addr(wa);
      cpu_req.wdata = d_cpu;
      @(negedge clk);
      cpu_req.valid = 1'b0;
      cpu_req.we    = 1'b0;
      expect_eq("ww cpu valid", 32'd1, 32'(cpu_rsp.valid));
      expect_eq("ww cpu err", 32'd0, 32'(cpu_rsp.err));
      wait_bresp(resp);
      expect_eq("ww bus resp", 32'(`TCM_RESP_OKAY), 32'(resp));
      model[wa] = d_axi;
      cpu_op("ww cpu read", 1'b0, byte_addr(wa), '0);
      axi_read(byte_addr(wa), data, resp);
      expect_eq("ww bus read", d_axi, data);

      // CPU write on the word the bus reads, read held and sees CPU data
      wa    = tcm_waddr_t'($urandom);
      d_cpu = tcm_data_t'($urandom);
      ar.addr  = byte_addr(wa);
      ar_valid = 1'b1;
      #1;
      expect_eq("wr accept", 32'd1, 32'(ar_ready));
      @(negedge clk);
      ar_valid      = 1'b0;
      cpu_req.valid = 1'b1;
      cpu_req.we    = 1'b1;
      cpu_req.addr  = byte_addr(wa);
      cpu_req.wdata = d_cpu;
      model[wa]     = d_cpu;
      @(negedge clk);
      cpu_req.valid = 1'b0;
      cpu_req.we    = 1'b0;
      expect_eq("wr cpu valid", 32'd1, 32'(cpu_rsp.valid));
      wait_rresp(data, resp);
      expect_eq("wr bus resp", 32'(`TCM_RESP_OKAY), 32'(resp));
      expect_eq("wr bus data", d_cpu, data);

      // Partial strobe refused
      wa      = tcm_waddr_t'($urandom);
      strb    = '1;
      strb[0] = 1'b0;
      axi_write(byte_addr(wa), tcm_data_t'($urandom), strb, resp);
      expect_eq("strb resp", 32'(`TCM_RESP_SLVERR), 32'(resp));
      axi_read(byte_addr(wa), data, resp);
      expect_eq("strb unchanged", model[wa], data);

      // Bus beyond the RAM, low bits alias an existing word
      wa  = tcm_waddr_t'($urandom);
      far = byte_addr(wa) | (32'd1 << (`TCM_AW + 2));
      axi_write(far, tcm_data_t'($urandom), '1, resp);
      expect_eq("range write resp", 32'(`TCM_RESP_DECERR), 32'(resp));
      axi_read(far, data, resp);
      expect_eq("range read resp", 32'(`TCM_RESP_DECERR), 32'(resp));
      axi_read(byte_addr(wa), data, resp);
      expect_eq("range unchanged", model[wa], data);

      // CPU out of range and misaligned
      cpu_op("cpu range write", 1'b1, far, tcm_data_t'($urandom));
      cpu_op("cpu range read", 1'b0, far, '0);
      cpu_op("cpu misaligned write", 1'b1, byte_addr(wa) | 32'd1, tcm_data_t'($urandom));
      cpu_op("cpu misaligned read", 1'b0, byte_addr(wa) | 32'd2, '0);
      cpu_op("cpu error unchanged", 1'b0, byte_addr(wa), '0);

      $display("Checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- bench/tcm_chk.sv
`timescale 1ns/1ps

module tcm_chk (
   input logic                clk,
   input logic                rst_n,
   input logic                en_a,
   input logic                we_a,
   input tcm_pkg::tcm_waddr_t addr_a,
   input logic                en_b,
   input logic                we_b,
   input tcm_pkg::tcm_waddr_t addr_b,
   input tcm_pkg::tcm_data_t  dout_a,
   input logic                bypass_q
);
   import tcm_pkg::*;

   // Both ports writing one word in one cycle
   property no_dual_write;
      @(posedge clk) disable iff (!rst_n)
         (en_a && we_a && en_b && we_b) |-> (addr_a != addr_b);
   endproperty

   // Port A write against a port B read of the same word
   property no_write_read;
      @(posedge clk) disable iff (!rst_n)
         (en_a && we_a && en_b && !we_b) |-> (addr_a != addr_b);
   endproperty

   // Captured B data held on dout_a while port A idles
   property bypass_hold;
      @(posedge clk) disable iff (!rst_n)
         (bypass_q && !en_a) |=> $stable(dout_a);
   endproperty

   a_no_dual_write: assert property (no_dual_write)
      else $error("Ports A and B wrote word %h in the same cycle", addr_a);

   a_no_write_read: assert property (no_write_read)
      else $error("Port A wrote word %h while port B read it", addr_a);

   a_bypass_hold: assert property (bypass_hold)
      else $error("dout_a changed while bypass flag set and port A idle");

endmodule

//--- logic/tcm_top.sv
`timescale 1ns/1ps

module tcm_top (
   input  logic              clk,
   input  logic              rst_n,
   // AXI4-Lite slave
   input  tcm_pkg::axil_aw_t aw,
   input  logic              aw_valid,
   output logic              aw_ready,
   input  tcm_pkg::axil_w_t  w,
   input  logic              w_valid,
   output logic              w_ready,
   input  tcm_pkg::axil_ar_t ar,
   input  logic              ar_valid,
   output logic              ar_ready,
   output tcm_pkg::axil_b_t  b,
   output logic              b_valid,
   input  logic              b_ready,
   output tcm_pkg::axil_r_t  r,
   output logic              r_valid,
   input  logic              r_ready,
   // CPU load/store
   input  tcm_pkg::cpu_req_t cpu_req,
   output tcm_pkg::cpu_rsp_t cpu_rsp
);
   import tcm_pkg::*;

   // Port A, also watched by the bus slave
   logic       en_a;
   logic       we_a;
   tcm_waddr_t addr_a;
   tcm_data_t  din_a;
   tcm_data_t  dout_a;
   // Port B
   logic       en_b;
   logic       we_b;
   tcm_waddr_t addr_b;
   tcm_data_t  din_b;
   tcm_data_t  dout_b;

   tcm_cpu_port u_cpu_port (
      .clk     (clk),
      .rst_n   (rst_n),
      .cpu_req (cpu_req),
      .cpu_rsp (cpu_rsp),
      .en_a    (en_a),
      .we_a    (we_a),
      .addr_a  (addr_a),
      .din_a   (din_a),
      .dout_a  (dout_a)
   );

   tcm_axil_slave u_axil_slave (
      .clk      (clk),
      .rst_n    (rst_n),
      .aw       (aw),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .w        (w),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .ar       (ar),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .b        (b),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .r        (r),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .a_en     (en_a),
      .a_we     (we_a),
      .a_addr   (addr_a),
      .en_b     (en_b),
      .we_b     (we_b),
      .addr_b   (addr_b),
      .din_b    (din_b),
      .dout_b   (dout_b)
   );

   tcm_tdpram u_tdpram (
      .clk    (clk),
      .rst_n  (rst_n),
      .addr_a (addr_a),
      .we_a   (we_a),
      .en_a   (en_a),
      .din_a  (din_a),
      .dout_a (dout_a),
      .addr_b (addr_b),
      .we_b   (we_b),
      .en_b   (en_b),
      .din_b  (din_b),
      .dout_b (dout_b)
   );

endmodule

//--- logic/tcm_axil_slave.sv
`timescale 1ns/1ps
`include "tcm_macros.svh"

module tcm_axil_slave (
   input  logic                clk,
   input  logic                rst_n,
   // Write address and data
   input  tcm_pkg::axil_aw_t   aw,
   input  logic                aw_valid,
   output logic                aw_ready,
   input  tcm_pkg::axil_w_t    w,
   input  logic                w_valid,
   output logic                w_ready,
   // Read address
   input  tcm_pkg::axil_ar_t   ar,
   input  logic                ar_valid,
   output logic                ar_ready,
   // Responses
   output tcm_pkg::axil_b_t    b,
   output logic                b_valid,
   input  logic                b_ready,
   output tcm_pkg::axil_r_t    r,
   output logic                r_valid,
   input  logic                r_ready,
   // Port A access seen this cycle
   input  logic                a_en,
   input  logic                a_we,
   input  tcm_pkg::tcm_waddr_t a_addr,
   // RAM port B
   output logic                en_b,
   output logic                we_b,
   output tcm_pkg::tcm_waddr_t addr_b,
   output tcm_pkg::tcm_data_t  din_b,
   input  tcm_pkg::tcm_data_t  dout_b
);
   import tcm_pkg::*;

   axil_state_t state_q;
   axil_state_t state_d;
   tcm_waddr_t  addr_q;
   tcm_data_t   data_q;
   tcm_resp_t   resp_q;

   logic        idle;
   logic        wr_both;
   logic        wr_take;
   logic        rd_take;
   logic        wr_bad_range;
   logic        wr_bad_strb;
   logic        rd_bad_range;
   logic        cpu_hit;

   assign idle    = (state_q == IDLE);
   assign wr_both = aw_valid && w_valid;

   // AW and W taken together, write wins over read
   assign wr_take  = idle && wr_both;
   assign aw_ready = wr_take;
   assign w_ready  = wr_take;
   assign ar_ready = idle && !wr_both;
   assign rd_take  = ar_ready && ar_valid;

   // Decode checks on the incoming request
   assign wr_bad_range = (aw.addr >> (`TCM_AW + 2)) != '0;
   assign rd_bad_range = (ar.addr >> (`TCM_AW + 2)) != '0;
   // Only full-word writes
   assign wr_bad_strb  = (w.strb != '1);

   // CPU writing our word this cycle, it wins and we wait
   // Covers both write/write and CPU write vs bus read
   assign cpu_hit = a_en && a_we && (a_addr == addr_q);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (wr_take) begin
               // Refused writes go straight to the response
               state_d = (wr_bad_range || wr_bad_strb) ? BRESP : WRITE;
            end else if (rd_take) begin
               state_d = rd_bad_range ? RRESP : READ;
            end
         end
         WRITE: begin
            if (!cpu_hit) begin
               state_d = BRESP;
            end
         end
         READ: begin
            if (!cpu_hit) begin
               state_d = RRESP;
            end
         end
         BRESP: begin
            if (b_ready) begin
               state_d = IDLE;
            end
         end
         RRESP: begin
            if (r_ready) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Request payload, held until the response completes
   always_ff @(posedge clk) begin
      if (wr_take) begin
         addr_q <= aw.addr[`TCM_AW+1:2];
         data_q <= w.data;
         if (wr_bad_range) begin
            resp_q <= `TCM_RESP_DECERR;
         end else if (wr_bad_strb) begin
            resp_q <= `TCM_RESP_SLVERR;
         end else begin
            resp_q <= `TCM_RESP_OKAY;
         end
      end else if (rd_take) begin
         addr_q <= ar.addr[`TCM_AW+1:2];
         resp_q <= rd_bad_range ? `TCM_RESP_DECERR : `TCM_RESP_OKAY;
      end
   end

   // Port B access in WRITE or READ unless the CPU takes the word
   assign en_b   = ((state_q == WRITE) || (state_q == READ)) && !cpu_hit;
   assign we_b   = (state_q == WRITE);
   assign addr_b = addr_q;
   assign din_b  = data_q;

   // Write response
   assign b_valid = (state_q == BRESP);
   assign b.resp  = resp_q;

   // Read data sits in the RAM output register
   // No port B access until the R beat is gone, so it stays stable
   assign r_valid = (state_q == RRESP);
   assign r.resp  = resp_q;
   assign r.data  = (resp_q == `TCM_RESP_OKAY) ? dout_b : '0;

endmodule

//--- logic/tcm_cpu_port.sv
`timescale 1ns/1ps
`include "tcm_macros.svh"

module tcm_cpu_port (
   input  logic                clk,
   input  logic                rst_n,
   input  tcm_pkg::cpu_req_t   cpu_req,
   output tcm_pkg::cpu_rsp_t   cpu_rsp,
   // RAM port A
   output logic                en_a,
   output logic                we_a,
   output tcm_pkg::tcm_waddr_t addr_a,
   output tcm_pkg::tcm_data_t  din_a,
   input  tcm_pkg::tcm_data_t  dout_a
);
   import tcm_pkg::*;

   logic in_range;
   logic aligned;
   logic legal;
   logic valid_q;
   logic err_q;

   // Byte address must fall inside the RAM
   assign in_range = (cpu_req.addr >> (`TCM_AW + 2)) == '0;
   // Word accesses only
   assign aligned  = (cpu_req.addr[1:0] == 2'b00);
   assign legal    = in_range && aligned;

   // Illegal requests never reach the RAM
   assign en_a   = cpu_req.valid && legal;
   assign we_a   = cpu_req.valid && legal && cpu_req.we;
   assign addr_a = cpu_req.addr[`TCM_AW+1:2];
   assign din_a  = cpu_req.wdata;

   // Status one cycle later, lined up with the RAM output
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         valid_q <= cpu_req.valid;
         err_q   <= cpu_req.valid && !legal;
      end
   end

   assign cpu_rsp.valid = valid_q;
   assign cpu_rsp.err   = err_q;
   // RAM output holds between port A accesses
   assign cpu_rsp.rdata = dout_a;

endmodule

//--- logic/tcm_tdpram.sv
`timescale 1ns/1ps
`include "tcm_macros.svh"

module tcm_tdpram (
   input  logic                clk,
   input  logic                rst_n,
   // Port A, CPU side
   input  tcm_pkg::tcm_waddr_t addr_a,
   input  logic                we_a,
   input  logic                en_a,
   input  tcm_pkg::tcm_data_t  din_a,
   output tcm_pkg::tcm_data_t  dout_a,
   // Port B, bus side
   input  tcm_pkg::tcm_waddr_t addr_b,
   input  logic                we_b,
   input  logic                en_b,
   input  tcm_pkg::tcm_data_t  din_b,
   output tcm_pkg::tcm_data_t  dout_b
);
   import tcm_pkg::*;

   localparam int unsigned depth = 1 << `TCM_AW;

   tcm_data_t mem [depth];
   tcm_data_t dout_a_q;
   tcm_data_t dout_b_q;
   // Port A enable after bypass decision
   logic      ram_en_a;
   // Set while dout_a shows captured port B data
   logic      bypass_q;

   // Zeroed contents at start of simulation
   initial begin : init_mem
      int unsigned i;
      for (i = 0; i < depth; i++) begin
         mem[i] = '0;
      end
   end

   // Both ports in one process
   // Write-first on each port, reads see the old word of the other port
   always @(posedge clk) begin
      if (ram_en_a && we_a) begin
         mem[addr_a] <= din_a;
         dout_a_q    <= din_a;
      end else if (ram_en_a) begin
         dout_a_q <= mem[addr_a];
      end

      if (en_b && we_b) begin
         mem[addr_b] <= din_b;
         dout_b_q    <= din_b;
      end else if (en_b) begin
         dout_b_q <= mem[addr_b];
      end
   end

   generate
      if (`TCM_ENABLE_BYPASS != 0) begin : g_bypass
         tcm_data_t din_b_q;
         logic      hit;

         // Port B write on the word port A accesses
         assign hit = en_a && en_b && we_b && (addr_a == addr_b);

         // Flag follows every port A access, kept while A idles
         always_ff @(posedge clk) begin
            if (!rst_n) begin
               bypass_q <= 1'b0;
            end else if (en_a) begin
               bypass_q <= hit;
            end
         end

         // B data captured alongside each A access
         always_ff @(posedge clk) begin
            if (en_a) begin
               din_b_q <= din_b;
            end
         end

         // Skip the array read on a hit
         assign ram_en_a = en_a && !hit;
         assign dout_a   = bypass_q ? din_b_q : dout_a_q;
      end else begin : g_no_bypass
         assign bypass_q = 1'b0;
         assign ram_en_a = en_a;
         assign dout_a   = dout_a_q;
      end
   endgenerate

   assign dout_b = dout_b_q;

endmodule

//--- logic/tcm_pkg.sv
`include "tcm_macros.svh"

package tcm_pkg;

   // Widths with a meaning
   typedef logic [31:0]             tcm_baddr_t;
   typedef logic [`TCM_AW-1:0]      tcm_waddr_t;
   typedef logic [`TCM_DW-1:0]      tcm_data_t;
   typedef logic [`TCM_DW/8-1:0]    tcm_strb_t;
   typedef logic [1:0]              tcm_resp_t;

   // AXI4-Lite request payloads
   typedef struct packed {
      tcm_baddr_t addr;
   } axil_aw_t;

   typedef struct packed {
      tcm_data_t data;
      tcm_strb_t strb;
   } axil_w_t;

   typedef struct packed {
      tcm_baddr_t addr;
   } axil_ar_t;

   // AXI4-Lite response payloads
   typedef struct packed {
      tcm_resp_t resp;
   } axil_b_t;

   typedef struct packed {
      tcm_data_t data;
      tcm_resp_t resp;
   } axil_r_t;

   // CPU load/store port, no handshake
   typedef struct packed {
      logic       valid;
      logic       we;
      tcm_baddr_t addr;
      tcm_data_t  wdata;
   } cpu_req_t;

   typedef struct packed {
      logic      valid;
      logic      err;
      tcm_data_t rdata;
   } cpu_rsp_t;

   // Bus slave FSM
   typedef enum logic [2:0] {
      IDLE,
      WRITE,
      READ,
      BRESP,
      RRESP
   } axil_state_t;

endpackage

//--- include/tcm_macros.svh
`ifndef TCM_MACROS_SVH
`define TCM_MACROS_SVH

// Word address width of the RAM, 1024 words by default
`define TCM_AW 10

// Data word width
`define TCM_DW 32

// Port B write data forwarded to port A on same-word hit
`define TCM_ENABLE_BYPASS 1

// AXI response codes
`define TCM_RESP_OKAY   2'b00
`define TCM_RESP_SLVERR 2'b10
`define TCM_RESP_DECERR 2'b11

`endif
